// ==== logic/opfetch_params.svh ====
`ifndef OPFETCH_PARAMS_SVH
`define OPFETCH_PARAMS_SVH

// memory port widths
`define OPF_ADDR_W    32
`define OPF_DATA_W    32
`define OPF_REG_NUM_W 4

// cond, src1, src0 slots plus the dst write of the sequencer
`define OPF_NUM_SLOTS 3
`define OPF_REQ_NUM   4

// register number fields of the command word
`define OPF_NUM_LSB_COND 12
`define OPF_NUM_LSB_SRC1 0
`define OPF_NUM_LSB_SRC0 4
`define OPF_NUM_LSB_DST  8

// pointer flags
`define OPF_PTR_BIT_COND 19
`define OPF_PTR_BIT_SRC1 16
`define OPF_PTR_BIT_SRC0 17

// post-modify mode fields
`define OPF_MODE_LSB_COND 26
`define OPF_MODE_LSB_SRC1 20
`define OPF_MODE_LSB_SRC0 22
`define OPF_MODE_LSB_DST  24

// slot order, also the fetch and writeback order
`define OPF_SLOT_COND 0
`define OPF_SLOT_SRC1 1
`define OPF_SLOT_SRC0 2

`endif

// ==== logic/opfetch_pkg.sv ====
`include "opfetch_params.svh"

package opfetch_pkg;

  typedef logic [`OPF_ADDR_W-1:0]    mem_addr_t;
  typedef logic [`OPF_DATA_W-1:0]    mem_data_t;
  typedef logic [31:0]               cmd_word_t;
  typedef logic [`OPF_REG_NUM_W-1:0] reg_num_t;
  // 01 increments, 10 decrements, others keep the value
  typedef logic [1:0]                post_mode_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_FETCH,
    SEQ_STORE_DST,
    SEQ_WAIT_DST,
    SEQ_STORE_WB,
    SEQ_WAIT_WB
  } seq_state_t;

  typedef enum logic [1:0] {
    SLOT_IDLE,
    SLOT_READ_REG,
    SLOT_READ_PTR,
    SLOT_WRITE
  } slot_state_t;

  // post-modify arithmetic, shared by the dst store and the writebacks
  function automatic mem_data_t post_modify(mem_data_t data, post_mode_t mode);
    case (mode)
      2'b01:   return data + 1'b1;
      2'b10:   return data - 1'b1;
      default: return data;
    endcase
  endfunction

endpackage

// ==== logic/opfetch_sequencer.sv ====
`timescale 1ns/10ps
`include "opfetch_params.svh"

module opfetch_sequencer
  import opfetch_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_start,
  input  logic                       store_start,
  input  cmd_word_t                  command,
  input  mem_addr_t                  base_addr,
  input  mem_data_t                  result,
  input  logic [`OPF_NUM_SLOTS-1:0]  slot_done,
  input  mem_data_t                  cond_value,
  input  logic                       dst_mem_done,
  output logic [`OPF_NUM_SLOTS-1:0]  slot_fetch_go,
  output logic [`OPF_NUM_SLOTS-1:0]  slot_wb_go,
  output mem_addr_t                  slot_addr [`OPF_NUM_SLOTS],
  output logic [`OPF_NUM_SLOTS-1:0]  slot_is_ptr,
  output post_mode_t                 slot_mode [`OPF_NUM_SLOTS],
  output logic                       dst_write_q,
  output mem_addr_t                  dst_addr,
  output mem_data_t                  dst_wdata,
  output logic                       fetch_done,
  output logic                       store_done
);

  localparam int IDX_W = $clog2(`OPF_NUM_SLOTS);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`OPF_NUM_SLOTS - 1);
  localparam logic [IDX_W-1:0] COND_IDX = IDX_W'(`OPF_SLOT_COND);

  seq_state_t       state;
  cmd_word_t        cmd_r;
  mem_addr_t        base_r;
  logic [IDX_W-1:0] slot_idx;
  logic [IDX_W-1:0] next_idx;
  logic             last_slot;
  logic             skip_wb;
  reg_num_t         cond_num;
  reg_num_t         src1_num;
  reg_num_t         src0_num;
  reg_num_t         dst_num;
  post_mode_t       dst_mode;

  // field decode of the latched command
  assign cond_num = cmd_r[`OPF_NUM_LSB_COND +: `OPF_REG_NUM_W];
  assign src1_num = cmd_r[`OPF_NUM_LSB_SRC1 +: `OPF_REG_NUM_W];
  assign src0_num = cmd_r[`OPF_NUM_LSB_SRC0 +: `OPF_REG_NUM_W];
  assign dst_num  = cmd_r[`OPF_NUM_LSB_DST +: `OPF_REG_NUM_W];
  assign dst_mode = cmd_r[`OPF_MODE_LSB_DST +: 2];

  // registers sit at base plus register number
  assign slot_addr[`OPF_SLOT_COND] = base_r + mem_addr_t'(cond_num);
  assign slot_addr[`OPF_SLOT_SRC1] = base_r + mem_addr_t'(src1_num);
  assign slot_addr[`OPF_SLOT_SRC0] = base_r + mem_addr_t'(src0_num);
  assign dst_addr                  = base_r + mem_addr_t'(dst_num);

  assign slot_is_ptr[`OPF_SLOT_COND] = cmd_r[`OPF_PTR_BIT_COND];
  assign slot_is_ptr[`OPF_SLOT_SRC1] = cmd_r[`OPF_PTR_BIT_SRC1];
  assign slot_is_ptr[`OPF_SLOT_SRC0] = cmd_r[`OPF_PTR_BIT_SRC0];

  assign slot_mode[`OPF_SLOT_COND] = cmd_r[`OPF_MODE_LSB_COND +: 2];
  assign slot_mode[`OPF_SLOT_SRC1] = cmd_r[`OPF_MODE_LSB_SRC1 +: 2];
  assign slot_mode[`OPF_SLOT_SRC0] = cmd_r[`OPF_MODE_LSB_SRC0 +: 2];

  assign next_idx  = slot_idx + 1'b1;
  assign last_slot = (slot_idx == LAST_IDX);
  // zero cond suppresses src writebacks, cond itself still goes
  assign skip_wb   = (slot_idx != COND_IDX) && (cond_value == '0);

  // command, base and dst data captured at the start pulses
  always_ff @(posedge clk) begin
    if (state == SEQ_IDLE && fetch_start) begin
      cmd_r  <= command;
      base_r <= base_addr;
    end
    if (state == SEQ_IDLE && store_start) begin
      dst_wdata <= post_modify(result, dst_mode);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= SEQ_IDLE;
      slot_idx      <= '0;
      slot_fetch_go <= '0;
      slot_wb_go    <= '0;
      dst_write_q   <= 1'b0;
      fetch_done    <= 1'b0;
      store_done    <= 1'b0;
    end else begin
      // all go and done outputs are single-cycle pulses
      slot_fetch_go <= '0;
      slot_wb_go    <= '0;
      dst_write_q   <= 1'b0;
      fetch_done    <= 1'b0;
      store_done    <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          slot_idx <= '0;
          if (fetch_start) begin
            slot_fetch_go[`OPF_SLOT_COND] <= 1'b1;
            state <= SEQ_FETCH;
          end else if (store_start) begin
            state <= SEQ_STORE_DST;
          end
        end
        SEQ_FETCH: begin
          if (slot_done[slot_idx]) begin
            if (last_slot) begin
              fetch_done <= 1'b1;
              state <= SEQ_IDLE;
            end else begin
              // next slot only after the previous one finished
              slot_idx <= next_idx;
              slot_fetch_go[next_idx] <= 1'b1;
            end
          end
        end
        SEQ_STORE_DST: begin
          dst_write_q <= 1'b1;
          state <= SEQ_WAIT_DST;
        end
        SEQ_WAIT_DST: begin
          if (dst_mem_done) begin
            slot_idx <= '0;
            state <= SEQ_STORE_WB;
          end
        end
        SEQ_STORE_WB: begin
          if (skip_wb) begin
            if (last_slot) begin
              store_done <= 1'b1;
              state <= SEQ_IDLE;
            end else begin
              slot_idx <= next_idx;
            end
          end else begin
            slot_wb_go[slot_idx] <= 1'b1;
            state <= SEQ_WAIT_WB;
          end
        end
        SEQ_WAIT_WB: begin
          if (slot_done[slot_idx]) begin
            if (last_slot) begin
              store_done <= 1'b1;
              state <= SEQ_IDLE;
            end else begin
              slot_idx <= next_idx;
              state <= SEQ_STORE_WB;
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

// ==== logic/operand_slot.sv ====
`timescale 1ns/10ps

module operand_slot
  import opfetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       fetch_go,
  input  logic       wb_go,
  input  logic       is_ptr,
  input  mem_addr_t  reg_addr,
  input  post_mode_t mode,
  input  mem_data_t  mem_rdata,
  input  logic       read_dn,
  input  logic       write_dn,
  output logic       req_read,
  output logic       req_write,
  output mem_addr_t  req_addr,
  output mem_data_t  req_wdata,
  output logic       done,
  output mem_data_t  value
);

  slot_state_t state;
  // register content, the pointer for a pointer operand
  mem_data_t   reg_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= SLOT_IDLE;
      req_read  <= 1'b0;
      req_write <= 1'b0;
      done      <= 1'b0;
    end else begin
      req_read  <= 1'b0;
      req_write <= 1'b0;
      done      <= 1'b0;
      case (state)
        SLOT_IDLE: begin
          if (fetch_go) begin
            req_read <= 1'b1;
            state <= SLOT_READ_REG;
          end else if (wb_go) begin
            // only modes 01 and 10 touch memory
            if (^mode) begin
              req_write <= 1'b1;
              state <= SLOT_WRITE;
            end else begin
              done <= 1'b1;
            end
          end
        end
        SLOT_READ_REG: begin
          if (read_dn) begin
            if (is_ptr) begin
              // second read at the address found in the register
              req_read <= 1'b1;
              state <= SLOT_READ_PTR;
            end else begin
              done <= 1'b1;
              state <= SLOT_IDLE;
            end
          end
        end
        SLOT_READ_PTR, SLOT_WRITE: begin
          if (read_dn || write_dn) begin
            done <= 1'b1;
            state <= SLOT_IDLE;
          end
        end
        default: state <= SLOT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SLOT_IDLE) begin
      req_addr  <= reg_addr;
      req_wdata <= post_modify(reg_data, mode);
    end
    if (state == SLOT_READ_REG && read_dn) begin
      reg_data <= mem_rdata;
      // pointer target for the indirect read
      req_addr <= mem_rdata;
      if (!is_ptr) begin
        value <= mem_rdata;
      end
    end
    if (state == SLOT_READ_PTR && read_dn) begin
      value <= mem_rdata;
    end
  end

endmodule

// ==== logic/mem_port_mux.sv ====
`timescale 1ns/10ps
`include "opfetch_params.svh"

module mem_port_mux
  import opfetch_pkg::*;
#(
  parameter int NUM_REQ = `OPF_REQ_NUM
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [NUM_REQ-1:0] req_read,
  input  logic [NUM_REQ-1:0] req_write,
  input  mem_addr_t          req_addr [NUM_REQ],
  input  mem_data_t          req_wdata [NUM_REQ],
  output logic [NUM_REQ-1:0] read_dn,
  output logic [NUM_REQ-1:0] write_dn,
  output mem_data_t          rdata,
  output logic               mem_read_q,
  output logic               mem_write_q,
  output mem_addr_t          mem_addr,
  output mem_data_t          mem_wdata,
  input  logic               mem_read_dn,
  input  logic               mem_write_dn,
  input  mem_data_t          mem_rdata
);

  localparam int OWNER_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

  logic [OWNER_W-1:0] owner;
  logic [OWNER_W-1:0] grant;
  logic               busy;
  logic               any_req;

  assign any_req = |(req_read | req_write);

  // lowest index wins, scan from the top
  always_comb begin
    grant = '0;
    for (int i = NUM_REQ - 1; i >= 0; i--) begin
      if (req_read[i] || req_write[i]) begin
        grant = OWNER_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy        <= 1'b0;
      owner       <= '0;
      mem_read_q  <= 1'b0;
      mem_write_q <= 1'b0;
    end else begin
      mem_read_q  <= 1'b0;
      mem_write_q <= 1'b0;
      if (!busy && any_req) begin
        busy        <= 1'b1;
        owner       <= grant;
        mem_read_q  <= req_read[grant];
        mem_write_q <= req_write[grant];
      end else if (busy && (mem_read_dn || mem_write_dn)) begin
        busy <= 1'b0;
      end
    end
  end

  // address and data held until the response
  always_ff @(posedge clk) begin
    if (!busy && any_req) begin
      mem_addr  <= req_addr[grant];
      mem_wdata <= req_wdata[grant];
    end
  end

  // responses go to the owner only
  always_comb begin
    read_dn  = '0;
    write_dn = '0;
    if (busy) begin
      read_dn[owner]  = mem_read_dn;
      write_dn[owner] = mem_write_dn;
    end
  end

  assign rdata = mem_rdata;

endmodule

// ==== logic/opfetch_top.sv ====
`timescale 1ns/10ps
`include "opfetch_params.svh"

module opfetch_top
  import opfetch_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      fetch_start,
  input  logic      store_start,
  input  cmd_word_t command,
  input  mem_addr_t base_addr,
  input  mem_data_t result,
  output logic      fetch_done,
  output logic      store_done,
  output mem_data_t cond,
  output mem_data_t src1,
  output mem_data_t src0,
  output logic      mem_read_q,
  output logic      mem_write_q,
  output mem_addr_t mem_addr,
  output mem_data_t mem_wdata,
  input  logic      mem_read_dn,
  input  logic      mem_write_dn,
  input  mem_data_t mem_rdata
);

  // requester index of the dst write, just above the slots
  localparam int DST_REQ = `OPF_NUM_SLOTS;

  logic [`OPF_NUM_SLOTS-1:0] slot_fetch_go;
  logic [`OPF_NUM_SLOTS-1:0] slot_wb_go;
  logic [`OPF_NUM_SLOTS-1:0] slot_done;
  logic [`OPF_NUM_SLOTS-1:0] slot_is_ptr;
  mem_addr_t                 slot_addr [`OPF_NUM_SLOTS];
  post_mode_t                slot_mode [`OPF_NUM_SLOTS];
  mem_data_t                 slot_value [`OPF_NUM_SLOTS];

  logic [`OPF_REQ_NUM-1:0]   req_read;
  logic [`OPF_REQ_NUM-1:0]   req_write;
  logic [`OPF_REQ_NUM-1:0]   read_dn;
  logic [`OPF_REQ_NUM-1:0]   write_dn;
  mem_addr_t                 req_addr [`OPF_REQ_NUM];
  mem_data_t                 req_wdata [`OPF_REQ_NUM];
  mem_data_t                 rdata;

  logic                      dst_write_q;
  logic                      dst_mem_done;
  mem_addr_t                 dst_addr;
  mem_data_t                 dst_wdata;

  opfetch_sequencer u_sequencer (
    .clk           (clk),
    .rst           (rst),
    .fetch_start   (fetch_start),
    .store_start   (store_start),
    .command       (command),
    .base_addr     (base_addr),
    .result        (result),
    .slot_done     (slot_done),
    .cond_value    (slot_value[`OPF_SLOT_COND]),
    .dst_mem_done  (dst_mem_done),
    .slot_fetch_go (slot_fetch_go),
    .slot_wb_go    (slot_wb_go),
    .slot_addr     (slot_addr),
    .slot_is_ptr   (slot_is_ptr),
    .slot_mode     (slot_mode),
    .dst_write_q   (dst_write_q),
    .dst_addr      (dst_addr),
    .dst_wdata     (dst_wdata),
    .fetch_done    (fetch_done),
    .store_done    (store_done)
  );

  // cond, src1, src0 slots on requesters 0 to 2
  for (genvar i = 0; i < `OPF_NUM_SLOTS; i++) begin : g_slot
    operand_slot u_slot (
      .clk       (clk),
      .rst       (rst),
      .fetch_go  (slot_fetch_go[i]),
      .wb_go     (slot_wb_go[i]),
      .is_ptr    (slot_is_ptr[i]),
      .reg_addr  (slot_addr[i]),
      .mode      (slot_mode[i]),
      .mem_rdata (rdata),
      .read_dn   (read_dn[i]),
      .write_dn  (write_dn[i]),
      .req_read  (req_read[i]),
      .req_write (req_write[i]),
      .req_addr  (req_addr[i]),
      .req_wdata (req_wdata[i]),
      .done      (slot_done[i]),
      .value     (slot_value[i])
    );
  end

  // dst only ever writes
  assign req_read[DST_REQ]  = 1'b0;
  assign req_write[DST_REQ] = dst_write_q;
  assign req_addr[DST_REQ]  = dst_addr;
  assign req_wdata[DST_REQ] = dst_wdata;
  assign dst_mem_done       = write_dn[DST_REQ] | read_dn[DST_REQ];

  mem_port_mux #(
    .NUM_REQ (`OPF_REQ_NUM)
  ) u_mux (
    .clk          (clk),
    .rst          (rst),
    .req_read     (req_read),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .read_dn      (read_dn),
    .write_dn     (write_dn),
    .rdata        (rdata),
    .mem_read_q   (mem_read_q),
    .mem_write_q  (mem_write_q),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_read_dn  (mem_read_dn),
    .mem_write_dn (mem_write_dn),
    .mem_rdata    (mem_rdata)
  );

  assign cond = slot_value[`OPF_SLOT_COND];
  assign src1 = slot_value[`OPF_SLOT_SRC1];
  assign src0 = slot_value[`OPF_SLOT_SRC0];

endmodule

// ==== verification/opfetch_checker.sv ====
`timescale 1ns/10ps

module opfetch_checker (
  input logic clk,
  input logic rst,
  input logic mem_read_q,
  input logic mem_write_q,
  input logic mem_read_dn,
  input logic mem_write_dn
);

  // one request in flight at most
  logic outstanding;

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= 1'b0;
    end else if (mem_read_q || mem_write_q) begin
      outstanding <= 1'b1;
    end else if (mem_read_dn || mem_write_dn) begin
      outstanding <= 1'b0;
    end
  end

  // read and write strobes are exclusive
  a_one_strobe: assert property (@(posedge clk) disable iff (rst)
    !(mem_read_q && mem_write_q))
    else $error("read and write strobes high together");

  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    outstanding |-> !(mem_read_q || mem_write_q))
    else $error("new strobe while a request is outstanding");

  // response only for a request already issued
  a_done_after_strobe: assert property (@(posedge clk) disable iff (rst)
    (mem_read_dn || mem_write_dn) |-> outstanding)
    else $error("done pulse without a preceding strobe");

endmodule

bind opfetch_top opfetch_checker u_checker (
  .clk          (clk),
  .rst          (rst),
  .mem_read_q   (mem_read_q),
  .mem_write_q  (mem_write_q),
  .mem_read_dn  (mem_read_dn),
  .mem_write_dn (mem_write_dn)
);

// ==== verification/opfetch_tb.sv ====
`timescale 1ns/10ps
`include "opfetch_params.svh"

module opfetch_tb
  import opfetch_pkg::*;
;

  localparam mem_addr_t BASE    = 32'h40;
  localparam int        TIMEOUT = 200;

  logic      clk;
  logic      rst;
  logic      fetch_start;
  logic      store_start;
  cmd_word_t command;
  mem_addr_t base_addr;
  mem_data_t result;
  logic      fetch_done;
  logic      store_done;
  mem_data_t cond;
  mem_data_t src1;
  mem_data_t src0;
  logic      mem_read_q;
  logic      mem_write_q;
  mem_addr_t mem_addr;
  mem_data_t mem_wdata;
  logic      mem_read_dn;
  logic      mem_write_dn;
  mem_data_t mem_rdata;

  mem_data_t   mem [256];
  logic [31:0] lfsr;
  // memory model request state
  logic        pending;
  logic        p_write;
  mem_addr_t   p_addr;
  mem_data_t   p_wdata;
  logic [31:0] p_cnt;
  // address of the most recent request seen by the memory model
  mem_addr_t   last_addr;

  opfetch_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // global guard against a stuck run
  initial begin
    #1000000;
    $display("run exceeded its time limit");
    $display("Simulation FAILED");
    $fatal(1, "watchdog");
  end

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input mem_data_t exp, input mem_data_t act);
    if (exp !== act) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      $display("Simulation FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
    if (exp !== act) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      $display("Simulation FAILED");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAILED %s expected %b actual %b", name, exp, act);
      $display("Simulation FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  // memory model with 1 to 4 cycles of latency
  always @(negedge clk) begin
    logic [31:0] d;
    mem_read_dn  = 1'b0;
    mem_write_dn = 1'b0;
    if (!pending && (mem_read_q || mem_write_q)) begin
      if (mem_addr[31:8] != '0) begin
        stop_with_error("memory request address outside the 256-word model");
      end
      draw_bits(2, d);
      pending   = 1'b1;
      p_cnt     = d + 1;
      p_write   = mem_write_q;
      p_addr    = mem_addr;
      p_wdata   = mem_wdata;
      last_addr = mem_addr;
    end
    if (pending) begin
      if (p_cnt == 0) begin
        pending = 1'b0;
        if (p_write) begin
          mem[p_addr[7:0]] = p_wdata;
          mem_write_dn = 1'b1;
        end else begin
          mem_rdata   = mem[p_addr[7:0]];
          mem_read_dn = 1'b1;
        end
      end else begin
        p_cnt = p_cnt - 1;
      end
    end
  end

  function automatic logic [7:0] reg_index(reg_num_t n);
    return BASE[7:0] + {4'h0, n};
  endfunction

  // expected register after post-modify with 01 up and 10 down
  function automatic mem_data_t expect_mod(mem_data_t old, post_mode_t m);
    if (m == 2'b01) begin
      return old + 32'd1;
    end else if (m == 2'b10) begin
      return old - 32'd1;
    end
    return old;
  endfunction

  function automatic cmd_word_t make_cmd(reg_num_t c, reg_num_t s1, reg_num_t s0,
                                         reg_num_t d, logic [2:0] ptr,
                                         post_mode_t mc, post_mode_t m1,
                                         post_mode_t m0, post_mode_t md);
    cmd_word_t w;
    w = '0;
    w[`OPF_NUM_LSB_COND +: 4]  = c;
    w[`OPF_NUM_LSB_SRC1 +: 4]  = s1;
    w[`OPF_NUM_LSB_SRC0 +: 4]  = s0;
    w[`OPF_NUM_LSB_DST +: 4]   = d;
    // ptr is {cond, src1, src0}
    w[`OPF_PTR_BIT_COND]       = ptr[2];
    w[`OPF_PTR_BIT_SRC1]       = ptr[1];
    w[`OPF_PTR_BIT_SRC0]       = ptr[0];
    w[`OPF_MODE_LSB_COND +: 2] = mc;
    w[`OPF_MODE_LSB_SRC1 +: 2] = m1;
    w[`OPF_MODE_LSB_SRC0 +: 2] = m0;
    w[`OPF_MODE_LSB_DST +: 2]  = md;
    return w;
  endfunction

  task automatic wait_done(input logic is_store);
    int cycles;
    cycles = 0;
    while (!(is_store ? store_done : fetch_done)) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_with_error(is_store ? "store_done never arrived" : "fetch_done never arrived");
      end
    end
  endtask

  task automatic run_fetch(input cmd_word_t cmd);
    @(negedge clk);
    command     = cmd;
    fetch_start = 1'b1;
    @(negedge clk);
    fetch_start = 1'b0;
    wait_done(1'b0);
  endtask

  task automatic run_store(input mem_data_t res);
    @(negedge clk);
    result      = res;
    store_start = 1'b1;
    @(negedge clk);
    store_start = 1'b0;
    wait_done(1'b1);
  endtask

  task automatic test_reset();
    check_flag("reset_fetch_done", 1'b0, fetch_done);
    check_flag("reset_store_done", 1'b0, store_done);
    check_flag("reset_read_q", 1'b0, mem_read_q);
    check_flag("reset_write_q", 1'b0, mem_write_q);
  endtask

  task automatic test_direct_fetch();
    logic [31:0] r;
    reg_num_t    c;
    reg_num_t    s1;
    reg_num_t    s0;
    for (int k = 0; k < 6; k++) begin
      draw_bits(12, r);
      c  = r[11:8];
      s1 = r[7:4];
      s0 = r[3:0];
      run_fetch(make_cmd(c, s1, s0, 4'h0, 3'b000, 2'b00, 2'b00, 2'b00, 2'b00));
      check_data("direct_cond", mem[reg_index(c)], cond);
      check_data("direct_src1", mem[reg_index(s1)], src1);
      check_data("direct_src0", mem[reg_index(s0)], src0);
      // src0 is read last
      check_addr("direct_src0_addr", BASE + mem_addr_t'(s0), last_addr);
    end
  endtask

  task automatic test_pointer_fetch();
    mem[reg_index(4'h1)] = 32'h90;
    mem[reg_index(4'h2)] = 32'hA3;
    mem[reg_index(4'h3)] = 32'hB7;
    run_fetch(make_cmd(4'h1, 4'h2, 4'h3, 4'h0, 3'b111, 2'b00, 2'b00, 2'b00, 2'b00));
    check_data("ptr_cond", mem[8'h90], cond);
    check_data("ptr_src1", mem[8'hA3], src1);
    check_data("ptr_src0", mem[8'hB7], src0);
  endtask

  task automatic test_dst_store();
    mem_data_t res;
    for (int m = 0; m < 4; m++) begin
      res = 32'h1234_0000 + mem_data_t'(m);
      run_fetch(make_cmd(4'h1, 4'h2, 4'h3, 4'h5, 3'b000, 2'b00, 2'b00, 2'b00,
                         post_mode_t'(m)));
      run_store(res);
      check_data("dst_store", expect_mod(res, post_mode_t'(m)), mem[reg_index(4'h5)]);
      // no writebacks with source modes 00, so the dst write is the last access
      check_addr("dst_addr", BASE + 32'h5, last_addr);
    end
  endtask

  task automatic test_writeback();
    mem_data_t old_c;
    mem_data_t old_0;
    mem[reg_index(4'h6)] = 32'h0000_0042;
    mem[reg_index(4'h7)] = 32'h95;
    mem[reg_index(4'h8)] = 32'h0000_7777;
    old_c = mem[reg_index(4'h6)];
    old_0 = mem[reg_index(4'h8)];
    // src1 pointer gets decremented in its register
    run_fetch(make_cmd(4'h6, 4'h7, 4'h8, 4'h9, 3'b010, 2'b01, 2'b10, 2'b11, 2'b00));
    run_store(32'h5);
    check_data("wb_cond", expect_mod(old_c, 2'b01), mem[reg_index(4'h6)]);
    check_data("wb_src1_ptr", 32'h94, mem[reg_index(4'h7)]);
    check_data("wb_src0_keep", old_0, mem[reg_index(4'h8)]);
  endtask

  task automatic test_cond_gating();
    mem_data_t old_1;
    mem_data_t old_0;
    mem[reg_index(4'hA)] = 32'h0;
    mem[reg_index(4'hB)] = 32'h0000_1111;
    mem[reg_index(4'hC)] = 32'h0000_2222;
    old_1 = mem[reg_index(4'hB)];
    old_0 = mem[reg_index(4'hC)];
    run_fetch(make_cmd(4'hA, 4'hB, 4'hC, 4'hD, 3'b000, 2'b01, 2'b01, 2'b10, 2'b00));
    run_store(32'h9);
    check_data("gate_cond", 32'h1, mem[reg_index(4'hA)]);
    check_data("gate_src1", old_1, mem[reg_index(4'hB)]);
    check_data("gate_src0", old_0, mem[reg_index(4'hC)]);
  endtask

  initial begin
    rst          = 1'b1;
    fetch_start  = 1'b0;
    store_start  = 1'b0;
    command      = '0;
    base_addr    = BASE;
    result       = '0;
    mem_read_dn  = 1'b0;
    mem_write_dn = 1'b0;
    mem_rdata    = '0;
    lfsr         = 32'h6889;
    pending      = 1'b0;
    p_write      = 1'b0;
    p_addr       = '0;
    p_wdata      = '0;
    p_cnt        = '0;
    last_addr    = '0;
    // fill pattern from the full address byte
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, 8'hC3};
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    test_reset();
    test_direct_fetch();
    test_pointer_fetch();
    test_dst_store();
    test_writeback();
    test_cond_gating();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/opfetch_pkg.sv
logic/opfetch_sequencer.sv
logic/operand_slot.sv
logic/mem_port_mux.sv
logic/opfetch_top.sv
verification/opfetch_checker.sv
verification/opfetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the operand fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --assert --timing -f verilog.f \
  --top-module opfetch_tb -o opfetch_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/opfetch_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi
exit 0
